// ==== Bender.yml ====
package:
  name: rs_top

sources:
  - source/rs_cfg_pkg.sv
  - source/rs_types_pkg.sv
  - source/rs_issue_if.sv
  - source/rs_single_entry.sv
  - source/disp_selector.sv
  - source/issue_selector.sv
  - source/rs.sv
  - source/rs_top.sv
  - target: test
    files:
      - verification/rs_tb.sv

// ==== rs_top.f ====
source/rs_cfg_pkg.sv
source/rs_types_pkg.sv
source/rs_issue_if.sv
source/rs_single_entry.sv
source/disp_selector.sv
source/issue_selector.sv
source/rs.sv
source/rs_top.sv
verification/rs_tb.sv

// ==== source/disp_selector.sv ====
// ================================================
// Dispatch slot allocator
// Lowest empty entries go to valid slots in order
// ================================================
`timescale 1ns/1ps

module disp_selector
    import rs_cfg_pkg::*;
(
    input  logic [RS_DEPTH-1:0]                     empty_vec_i,
    input  logic [DISPATCH_WIDTH-1:0]               disp_valid_i,
    output logic [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant_o
);

    // Entries not yet handed to an earlier slot
    logic [RS_DEPTH-1:0] avail;

    always_comb begin : grant_scan
        logic found;
        avail   = empty_vec_i;
        grant_o = '0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            found = 1'b0;
            // Invalid slots consume nothing
            if (disp_valid_i[k]) begin
                for (int j = 0; j < RS_DEPTH; j++) begin
                    if (avail[j] && !found) begin
                        grant_o[k][j] = 1'b1;
                        avail[j]      = 1'b0;
                        found         = 1'b1;
                    end
                end
            end
        end
    end

    // Each slot owns at most one entry
    always_comb begin : grant_check
        if (!$isunknown(disp_valid_i) && !$isunknown(empty_vec_i)) begin
            for (int k = 0; k < DISPATCH_WIDTH; k++) begin
                assert final ($onehot0(grant_o[k]))
                    else $error("dispatch slot %0d granted several entries", k);
            end
        end
    end

endmodule : disp_selector

// ==== source/issue_selector.sv ====
// ================================================
// Issue selector
// Picks the lowest-index ready entries per cycle
// ================================================
`timescale 1ns/1ps

module issue_selector
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    rs_issue_if.select                     sel,
    output logic      [ISSUE_WIDTH-1:0]    issue_valid_o,
    output rs_entry_t [ISSUE_WIDTH-1:0]    issue_entry_o
);

    // Candidates still free for later ports
    logic [RS_DEPTH-1:0] remain;

    // ================================================
    // Priority pick
    // ================================================
    // Port 0 gets the lowest index, port 1 the next
    always_comb begin : pick
        logic taken;
        remain        = sel.ready & sel.valid;
        sel.issue_en  = '0;
        issue_valid_o = '0;
        issue_entry_o = '0;
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            taken = 1'b0;
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (remain[j] && !taken) begin
                    issue_valid_o[p] = 1'b1;
                    issue_entry_o[p] = sel.entries[j];
                    sel.issue_en[j]  = 1'b1;
                    remain[j]        = 1'b0;
                    taken            = 1'b1;
                end
            end
        end
    end

    // Enabled entry must be occupied with both stored sources woken
    always_comb begin : issue_check
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (sel.issue_en[j] === 1'b1) begin
                assert final (sel.valid[j] && sel.entries[j].src1_ready
                              && sel.entries[j].src2_ready)
                    else $error("issue enable raised for entry %0d that is not ready", j);
            end
        end
    end

endmodule : issue_selector

// ==== source/rs.sv ====
// ================================================
// Reservation station table
// Entry array, dispatch routing, free-slot count
// ================================================
`timescale 1ns/1ps

module rs
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    input  logic                                clock,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // Dispatch
    input  logic      [DISPATCH_WIDTH-1:0]      disp_valid_i,
    input  rs_entry_t [DISPATCH_WIDTH-1:0]      disp_packet_i,

    // CDB
    input  logic      [CDB_WIDTH-1:0]           cdb_valid_i,
    input  logic      [CDB_WIDTH-1:0][TAG_W-1:0] cdb_tag_i,

    rs_issue_if.entry_table                     tbl,

    output logic      [FREE_W-1:0]              free_slots_o,
    output logic                                rs_full_o
);

    logic      [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant;
    logic      [RS_DEPTH-1:0]                     disp_en;
    rs_entry_t [RS_DEPTH-1:0]                     entry_pkt;
    logic      [RS_DEPTH-1:0]                     empty_vec;
    rs_entry_t [RS_DEPTH-1:0]                     entries;
    logic      [RS_DEPTH-1:0]                     ready_vec;
    logic      [FREE_W-1:0]                       free_cnt;

    // ================================================
    // Dispatch routing
    // ================================================
    disp_selector u_disp_sel (
        .empty_vec_i  (empty_vec),
        .disp_valid_i (disp_valid_i),
        .grant_o      (grant)
    );

    // Grant rows are disjoint so each entry sees one packet at most
    always_comb begin : route
        entry_pkt = '0;
        disp_en   = '0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (grant[k][j]) begin
                    entry_pkt[j] = disp_packet_i[k];
                    disp_en[j]   = 1'b1;
                end
            end
        end
    end

    // ================================================
    // Entry array
    // ================================================
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_single_entry u_entry (
            .clock       (clock),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .disp_en_i   (disp_en[i]),
            .packet_i    (entry_pkt[i]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .issue_i     (tbl.issue_en[i]),
            .empty_o     (empty_vec[i]),
            .entry_o     (entries[i]),
            .ready_o     (ready_vec[i])
        );

        // An issued entry is gone one edge later
        a_issue_frees: assert property (
            @(posedge clock) disable iff (!rst_n_i)
            tbl.issue_en[i] |=> empty_vec[i]
        ) else $error("entry %0d still occupied after issue", i);
    end

    assign tbl.entries = entries;
    assign tbl.ready   = ready_vec;
    assign tbl.valid   = ~empty_vec;

    // ================================================
    // Free-slot report
    // ================================================
    always_comb begin : count_free
        free_cnt = '0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (empty_vec[j] && (free_cnt < FREE_W'(DISPATCH_WIDTH))) begin
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign free_slots_o = free_cnt;
    assign rs_full_o    = ~|empty_vec;

endmodule : rs

// ==== source/rs_cfg_pkg.sv ====
// ================================================
// Reservation station sizing
// Depth, port widths and tag geometry
// ================================================
package rs_cfg_pkg;

    // ================================================
    // Station and port geometry
    // ================================================
    // Entries in the scheduling window
    localparam int unsigned RS_DEPTH       = 8;
    // Renamed instructions accepted per cycle
    localparam int unsigned DISPATCH_WIDTH = 2;
    // Instructions sent to the FUs per cycle
    localparam int unsigned ISSUE_WIDTH    = 2;
    // Result broadcast lanes
    localparam int unsigned CDB_WIDTH      = 2;

    // ================================================
    // Tag and counter widths
    // ================================================
    localparam int unsigned PHYS_REGS      = 32;
    localparam int unsigned TAG_W          = $clog2(PHYS_REGS);
    // Free-slot count, saturates at dispatch width
    localparam int unsigned FREE_W         = $clog2(DISPATCH_WIDTH + 1);

endpackage : rs_cfg_pkg

// ==== source/rs_issue_if.sv ====
// ================================================
// Station table to issue selector link
// ================================================
`timescale 1ns/1ps

interface rs_issue_if import rs_cfg_pkg::*, rs_types_pkg::*; ();

    // Stored packets, one per entry
    rs_entry_t [RS_DEPTH-1:0] entries;
    // Both sources ready and entry occupied
    logic      [RS_DEPTH-1:0] ready;
    // Entry occupied
    logic      [RS_DEPTH-1:0] valid;
    // Entry leaves this cycle and clears at the next edge
    logic      [RS_DEPTH-1:0] issue_en;

    // Table side owns the state
    modport entry_table (output entries, output ready, output valid, input issue_en);
    // Selector side picks and returns the enables
    modport select      (input entries, input ready, input valid, output issue_en);

endinterface : rs_issue_if

// ==== source/rs_single_entry.sv ====
// ================================================
// Single reservation station entry
// Holds one packet, snoops the CDB for wakeup
// ================================================
`timescale 1ns/1ps

module rs_single_entry
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    input  logic                             clock,
    input  logic                             rst_n_i,
    input  logic                             flush_i,

    // Dispatch write
    input  logic                             disp_en_i,
    input  rs_entry_t                        packet_i,

    // Result broadcast
    input  logic [CDB_WIDTH-1:0]             cdb_valid_i,
    input  logic [CDB_WIDTH-1:0][TAG_W-1:0]  cdb_tag_i,

    // Issue clear
    input  logic                             issue_i,

    output logic                             empty_o,
    output rs_entry_t                        entry_o,
    output logic                             ready_o
);

    logic      occupied_q;
    rs_entry_t entry_q;
    rs_entry_t entry_base;
    rs_entry_t entry_nxt;
    logic      src1_hit;
    logic      src2_hit;

    // ================================================
    // Wakeup compare
    // ================================================
    // Incoming packet is checked on its dispatch cycle too
    assign entry_base = disp_en_i ? packet_i : entry_q;

    always_comb begin : wakeup
        src1_hit = 1'b0;
        src2_hit = 1'b0;
        for (int l = 0; l < CDB_WIDTH; l++) begin
            if (cdb_valid_i[l] && (cdb_tag_i[l] == entry_base.src1_tag)) begin
                src1_hit = 1'b1;
            end
            if (cdb_valid_i[l] && (cdb_tag_i[l] == entry_base.src2_tag)) begin
                src2_hit = 1'b1;
            end
        end
        entry_nxt            = entry_base;
        // Ready bits are sticky once set
        entry_nxt.src1_ready = entry_base.src1_ready | src1_hit;
        entry_nxt.src2_ready = entry_base.src2_ready | src2_hit;
    end

    // ================================================
    // State
    // ================================================
    // Flush wins over dispatch, dispatch over issue
    always_ff @(posedge clock) begin
        if (!rst_n_i || flush_i) begin
            occupied_q <= 1'b0;
        end else if (disp_en_i) begin
            occupied_q <= 1'b1;
        end else if (issue_i) begin
            occupied_q <= 1'b0;
        end
    end

    // Payload only moves while the slot is live
    always_ff @(posedge clock) begin
        if (disp_en_i || occupied_q) begin
            entry_q <= entry_nxt;
        end
    end

    assign empty_o = ~occupied_q;
    assign entry_o = entry_q;
    assign ready_o = occupied_q & entry_q.src1_ready & entry_q.src2_ready;

    // Dispatch selector only targets free slots
    a_no_overwrite: assert property (
        @(posedge clock) disable iff (!rst_n_i)
        disp_en_i |-> (!occupied_q || issue_i)
    ) else $error("dispatch wrote into an occupied entry");

endmodule : rs_single_entry

// ==== source/rs_top.sv ====
// ================================================
// Scheduling window top level
// Flat dispatch/issue fields around the station
// ================================================
`timescale 1ns/1ps

module rs_top
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
(
    input  logic                                   clock,
    input  logic                                   rst_n_i,
    input  logic                                   flush_i,

    // One dispatch field per slot
    input  logic     [DISPATCH_WIDTH-1:0]            disp_valid_i,
    input  logic     [DISPATCH_WIDTH-1:0][TAG_W-1:0] disp_dest_tag_i,
    input  logic     [DISPATCH_WIDTH-1:0][TAG_W-1:0] disp_src1_tag_i,
    input  logic     [DISPATCH_WIDTH-1:0]            disp_src1_ready_i,
    input  logic     [DISPATCH_WIDTH-1:0][TAG_W-1:0] disp_src2_tag_i,
    input  logic     [DISPATCH_WIDTH-1:0]            disp_src2_ready_i,
    input  opcode_t  [DISPATCH_WIDTH-1:0]            disp_opcode_i,
    input  fu_type_e [DISPATCH_WIDTH-1:0]            disp_fu_type_i,

    // CDB
    input  logic     [CDB_WIDTH-1:0]                 cdb_valid_i,
    input  logic     [CDB_WIDTH-1:0][TAG_W-1:0]      cdb_tag_i,

    output logic     [FREE_W-1:0]                    free_slots_o,
    output logic                                     rs_full_o,

    // One issue field per port
    output logic     [ISSUE_WIDTH-1:0]               issue_valid_o,
    output logic     [ISSUE_WIDTH-1:0][TAG_W-1:0]    issue_dest_tag_o,
    output opcode_t  [ISSUE_WIDTH-1:0]               issue_opcode_o,
    output fu_type_e [ISSUE_WIDTH-1:0]               issue_fu_type_o
);

    rs_entry_t [DISPATCH_WIDTH-1:0] disp_packet;
    rs_entry_t [ISSUE_WIDTH-1:0]    issue_entry;

    rs_issue_if issue_link ();

    // Pack dispatch fields into entries
    always_comb begin : pack
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            disp_packet[k].dest_tag   = disp_dest_tag_i[k];
            disp_packet[k].src1_tag   = disp_src1_tag_i[k];
            disp_packet[k].src1_ready = disp_src1_ready_i[k];
            disp_packet[k].src2_tag   = disp_src2_tag_i[k];
            disp_packet[k].src2_ready = disp_src2_ready_i[k];
            disp_packet[k].opcode     = disp_opcode_i[k];
            disp_packet[k].fu_type    = disp_fu_type_i[k];
        end
    end

    rs u_rs (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_i),
        .disp_valid_i  (disp_valid_i),
        .disp_packet_i (disp_packet),
        .cdb_valid_i   (cdb_valid_i),
        .cdb_tag_i     (cdb_tag_i),
        .tbl           (issue_link.entry_table),
        .free_slots_o  (free_slots_o),
        .rs_full_o     (rs_full_o)
    );

    issue_selector u_issue_sel (
        .sel           (issue_link.select),
        .issue_valid_o (issue_valid_o),
        .issue_entry_o (issue_entry)
    );

    // Split issued entries back into FU fields
    always_comb begin : unpack
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            issue_dest_tag_o[p] = issue_entry[p].dest_tag;
            issue_opcode_o[p]   = issue_entry[p].opcode;
            issue_fu_type_o[p]  = issue_entry[p].fu_type;
        end
    end

endmodule : rs_top

// ==== source/rs_types_pkg.sv ====
// ================================================
// Reservation station types
// FU class, opcode and entry layout
// ================================================
package rs_types_pkg;

    import rs_cfg_pkg::*;

    // Functional-unit class an entry is steered to
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_MEM    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    // Eight opcodes, meaning is local to each FU
    typedef logic [2:0] opcode_t;

    // ================================================
    // One station entry
    // ================================================
    // Tags only, operand values live in the PRF
    typedef struct packed {
        logic [TAG_W-1:0] dest_tag;
        logic [TAG_W-1:0] src1_tag;
        logic             src1_ready;
        logic [TAG_W-1:0] src2_tag;
        logic             src2_ready;
        opcode_t          opcode;
        fu_type_e         fu_type;
    } rs_entry_t;

endpackage : rs_types_pkg

// ==== verification/rs_tb.sv ====
// ================================================
// Scheduling window testbench
// Directed and seeded random traffic vs a model
// ================================================
`timescale 1ns/1ps

module rs_tb
    import rs_cfg_pkg::*;
    import rs_types_pkg::*;
();

    // Cycle budgets per test, reset included
    localparam int RANDOM_CYCLES = 300;
    localparam int BUDGET_CYCLES = 2 + 2 + 4 + 8 + 15 + 6 + RANDOM_CYCLES;
    localparam int MARGIN_CYCLES = 50;

    logic                                 clock;
    logic                                 rst_n_i;
    logic                                 flush_i;
    logic [DISPATCH_WIDTH-1:0]            disp_valid, disp_s1_rdy, disp_s2_rdy;
    logic [DISPATCH_WIDTH-1:0][TAG_W-1:0] disp_dest, disp_s1_tag, disp_s2_tag;
    opcode_t  [DISPATCH_WIDTH-1:0]        disp_op;
    fu_type_e [DISPATCH_WIDTH-1:0]        disp_fu;
    logic [CDB_WIDTH-1:0]                 cdb_valid;
    logic [CDB_WIDTH-1:0][TAG_W-1:0]      cdb_tag;
    logic [FREE_W-1:0]                    free_slots;
    logic                                 rs_full;
    logic [ISSUE_WIDTH-1:0]               issue_valid;
    logic [ISSUE_WIDTH-1:0][TAG_W-1:0]    issue_dest;
    opcode_t  [ISSUE_WIDTH-1:0]           issue_op;
    fu_type_e [ISSUE_WIDTH-1:0]           issue_fu;

    // Reference model state
    logic [RS_DEPTH-1:0]    m_occ;
    rs_entry_t              m_ent [RS_DEPTH];
    logic [ISSUE_WIDTH-1:0] exp_valid;
    int                     exp_idx [ISSUE_WIDTH];

    int seed = 32'ha8c8_168c;
    int errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;

    rs_top dut0 (
        .clock             (clock),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .disp_valid_i      (disp_valid),
        .disp_dest_tag_i   (disp_dest),
        .disp_src1_tag_i   (disp_s1_tag),
        .disp_src1_ready_i (disp_s1_rdy),
        .disp_src2_tag_i   (disp_s2_tag),
        .disp_src2_ready_i (disp_s2_rdy),
        .disp_opcode_i     (disp_op),
        .disp_fu_type_i    (disp_fu),
        .cdb_valid_i       (cdb_valid),
        .cdb_tag_i         (cdb_tag),
        .free_slots_o      (free_slots),
        .rs_full_o         (rs_full),
        .issue_valid_o     (issue_valid),
        .issue_dest_tag_o  (issue_dest),
        .issue_opcode_o    (issue_op),
        .issue_fu_type_o   (issue_fu)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // ================================================
    // Reference model
    // ================================================
    // Any valid lane carrying this tag
    function automatic logic tag_seen(input logic [TAG_W-1:0] tag);
        logic seen;
        seen = 1'b0;
        for (int l = 0; l < CDB_WIDTH; l++) begin
            if (cdb_valid[l] && (cdb_tag[l] == tag)) seen = 1'b1;
        end
        return seen;
    endfunction

    // Lowest ready entries go to port 0, then port 1
    function automatic void compute_expected();
        int p;
        p         = 0;
        exp_valid = '0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (m_occ[j] && m_ent[j].src1_ready && m_ent[j].src2_ready && p < ISSUE_WIDTH) begin
                exp_valid[p] = 1'b1;
                exp_idx[p]   = j;
                p++;
            end
        end
    endfunction

    // Empty entries, saturated at dispatch width
    function automatic int model_free();
        int n;
        n = 0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (!m_occ[j] && n < DISPATCH_WIDTH) n++;
        end
        return n;
    endfunction

    // State update at the rising edge
    task automatic model_edge();
        logic [RS_DEPTH-1:0] was_empty;
        int j;
        if (!rst_n_i || flush_i) begin
            m_occ = '0;
        end else begin
            compute_expected();
            was_empty = ~m_occ;
            for (int i = 0; i < RS_DEPTH; i++) begin
                m_ent[i].src1_ready = m_ent[i].src1_ready | tag_seen(m_ent[i].src1_tag);
                m_ent[i].src2_ready = m_ent[i].src2_ready | tag_seen(m_ent[i].src2_tag);
            end
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (exp_valid[p]) m_occ[exp_idx[p]] = 1'b0;
            end
            // Slot k takes the k-th lowest entry empty before this edge
            for (int k = 0; k < DISPATCH_WIDTH; k++) begin
                j = 0;
                while (disp_valid[k] && j < RS_DEPTH && !was_empty[j]) j++;
                if (disp_valid[k] && j < RS_DEPTH) begin
                    was_empty[j]        = 1'b0;
                    m_occ[j]            = 1'b1;
                    m_ent[j].dest_tag   = disp_dest[k];
                    m_ent[j].src1_tag   = disp_s1_tag[k];
                    m_ent[j].src1_ready = disp_s1_rdy[k] | tag_seen(disp_s1_tag[k]);
                    m_ent[j].src2_tag   = disp_s2_tag[k];
                    m_ent[j].src2_ready = disp_s2_rdy[k] | tag_seen(disp_s2_tag[k]);
                    m_ent[j].opcode     = disp_op[k];
                    m_ent[j].fu_type    = disp_fu[k];
                end
            end
        end
    endtask

    // ================================================
    // Checks and stimulus helpers
    // ================================================
    task automatic compare_field(input string name, input int port,
                                 input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            $display("Error: %s[%0d] exp %h got %h at %0t", name, port, exp, got, $time);
            errors++;
        end
    endtask

    task automatic check_outputs();
        compute_expected();
        compare_field("free_slots_o", 0, 8'(model_free()), 8'(free_slots));
        compare_field("rs_full_o", 0, 8'(m_occ == '1), 8'(rs_full));
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            compare_field("issue_valid_o", p, 8'(exp_valid[p]), 8'(issue_valid[p]));
            if (exp_valid[p] && issue_valid[p]) begin
                compare_field("issue_dest_tag_o", p, 8'(m_ent[exp_idx[p]].dest_tag),
                              8'(issue_dest[p]));
                compare_field("issue_opcode_o", p, 8'(m_ent[exp_idx[p]].opcode),
                              8'(issue_op[p]));
                compare_field("issue_fu_type_o", p, 8'(m_ent[exp_idx[p]].fu_type),
                              8'(issue_fu[p]));
            end
        end
    endtask

    // Entered 2 ns after an edge, left 2 ns after the next
    task automatic run_cycle();
        #8;
        if (rst_n_i) check_outputs();
        @(posedge clock);
        model_edge();
        #2;
    endtask

    task automatic idle_inputs();
        flush_i     = 1'b0;
        disp_valid  = '0;
        disp_dest   = '0;
        disp_s1_tag = '0;
        disp_s1_rdy = '0;
        disp_s2_tag = '0;
        disp_s2_rdy = '0;
        disp_op     = '0;
        disp_fu     = FU_ALU;
        cdb_valid   = '0;
        cdb_tag     = '0;
    endtask

    // Dest, opcode and FU class are random
    task automatic drive_slot(input int k, input logic [TAG_W-1:0] s1, input logic r1,
                              input logic [TAG_W-1:0] s2, input logic r2);
        logic [31:0] rnd;
        rnd            = $random(seed);
        disp_valid[k]  = 1'b1;
        disp_dest[k]   = rnd[TAG_W-1:0];
        disp_s1_tag[k] = s1;
        disp_s1_rdy[k] = r1;
        disp_s2_tag[k] = s2;
        disp_s2_rdy[k] = r2;
        disp_op[k]     = opcode_t'(rnd[7:5]);
        disp_fu[k]     = fu_type_e'(rnd[9:8]);
    endtask

    task automatic drive_cdb(input int l, input logic [TAG_W-1:0] tag);
        cdb_valid[l] = 1'b1;
        cdb_tag[l]   = tag;
    endtask

    task automatic close_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // ================================================
    // Test sequence
    // ================================================
    initial begin : main
        logic [31:0] rnd;
        logic [31:0] rnd2;
        int budget;
        errors          = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        m_occ           = '0;
        rst_n_i         = 1'b0;
        idle_inputs();
        repeat (2) run_cycle();
        rst_n_i = 1'b1;

        repeat (2) run_cycle();
        close_test("after_reset");

        // Both sources ready at dispatch
        drive_slot(0, 5'd1, 1'b1, 5'd2, 1'b1);
        drive_slot(1, 5'd3, 1'b1, 5'd4, 1'b1);
        run_cycle();
        idle_inputs();
        repeat (3) run_cycle();
        close_test("immediate_issue");

        // Tag 7 broadcast alongside the dispatch
        drive_slot(0, 5'd5, 1'b0, 5'd9, 1'b1);
        drive_slot(1, 5'd6, 1'b0, 5'd7, 1'b0);
        drive_cdb(0, 5'd7);
        run_cycle();
        idle_inputs();
        repeat (3) run_cycle();
        drive_cdb(0, 5'd5);
        drive_cdb(1, 5'd6);
        run_cycle();
        idle_inputs();
        repeat (3) run_cycle();
        close_test("wakeup");

        // One per cycle so the count walks 2, 1, 0
        for (int i = 0; i < RS_DEPTH; i++) begin
            idle_inputs();
            drive_slot(i % DISPATCH_WIDTH, 5'd20, 1'b0, 5'd21, 1'b1);
            run_cycle();
        end
        idle_inputs();
        run_cycle();
        drive_cdb(1, 5'd20);
        run_cycle();
        idle_inputs();
        repeat (5) run_cycle();
        close_test("fill_and_drain");

        drive_slot(0, 5'd25, 1'b0, 5'd26, 1'b1);
        drive_slot(1, 5'd25, 1'b0, 5'd27, 1'b1);
        run_cycle();
        // Flush beats the dispatch on the same edge
        flush_i = 1'b1;
        drive_slot(0, 5'd1, 1'b1, 5'd2, 1'b1);
        drive_slot(1, 5'd3, 1'b1, 5'd4, 1'b1);
        run_cycle();
        idle_inputs();
        drive_cdb(0, 5'd25);
        run_cycle();
        idle_inputs();
        repeat (3) run_cycle();
        close_test("flush");

        // Small tag range keeps wakeups frequent
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            idle_inputs();
            rnd    = $random(seed);
            rnd2   = $random(seed);
            budget = model_free();
            for (int k = 0; k < DISPATCH_WIDTH; k++) begin
                if (rnd[k] && budget > 0) begin
                    drive_slot(k, {2'b00, rnd[2+6*k +: 3]}, rnd[14+k],
                               {2'b00, rnd[5+6*k +: 3]}, rnd[16+k]);
                    budget--;
                end
            end
            for (int l = 0; l < CDB_WIDTH; l++) begin
                if (rnd2[l]) drive_cdb(l, {2'b00, rnd2[2+3*l +: 3]});
            end
            flush_i = (rnd2[15:11] == 5'd0);
            run_cycle();
        end
        close_test("random_traffic");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #((BUDGET_CYCLES + MARGIN_CYCLES) * 20);
        $display("Timeout: the run went past its cycle budget and was stopped");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule : rs_tb
